// File: logic/vldu_settings.svh
// Vector load unit settings

`ifndef VLDU_SETTINGS_SVH
`define VLDU_SETTINGS_SVH

// Number of lanes fed by the unit
`define VLDU_NR_LANES 4
// Lane word width, also the Wishbone data width
`define VLDU_LANE_W 64
// Wishbone byte address width
`define VLDU_ADDR_W 32
// In-flight load instructions
`define VLDU_INSN_DEPTH 4
// Words per lane in one vector register
`define VLDU_REG_WORDS 8
// Element count, up to 256 single-byte elements
`define VLDU_VL_W 9
// Instruction id
`define VLDU_ID_W 3

`endif

// File: logic/vldu_pkg.sv
// Vector load unit types

`default_nettype none

`include "vldu_settings.svh"

package vldu_pkg;

  // Element width, value is log2 of the element size in bytes
  typedef enum logic [1:0] {
    E8  = 2'd0,
    E16 = 2'd1,
    E32 = 2'd2,
    E64 = 2'd3
  } sew_e;

  // Wishbone fetch FSM
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,
    HOLD = 2'd2
  } fetch_state_e;

  // Word address in the lane register file, vd and word index
  typedef logic [4+$clog2(`VLDU_REG_WORDS):0] vrf_addr_t;

  // One unit-stride load
  typedef struct packed {
    logic [`VLDU_ID_W-1:0]   id;
    logic [4:0]              vd;
    sew_e                    sew;
    logic [`VLDU_VL_W-1:0]   vl;
    logic [`VLDU_ADDR_W-1:0] base;
  } load_insn_t;

endpackage

`default_nettype wire

// File: logic/vldu_beat_if.sv
// Memory beat channel

`timescale 1ns/1ps
`default_nettype none

`include "vldu_settings.svh"

interface vldu_beat_if;
  import vldu_pkg::*;

  logic                   valid;
  logic                   ready;
  logic [`VLDU_LANE_W-1:0] data;
  // Instruction fields travel with every beat
  sew_e                   sew;
  logic [4:0]             vd;
  logic [`VLDU_VL_W-1:0]  vl_bytes;
  logic                   first;
  logic                   last;

  modport src (output valid, data, sew, vd, vl_bytes, first, last, input ready);
  modport snk (input valid, data, sew, vd, vl_bytes, first, last, output ready);

endinterface

`default_nettype wire

// File: logic/vldu_insn_queue.sv
// Load instruction queue

`timescale 1ns/1ps
`default_nettype none

`include "vldu_settings.svh"

module vldu_insn_queue (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 req_valid_i,
  input  vldu_pkg::load_insn_t      req_insn_i,
  output logic                      req_ready_o,
  output vldu_pkg::load_insn_t      issue_insn_o,
  output logic                      issue_valid_o,
  input  wire logic                 issue_done_i,
  input  wire logic                 commit_i,
  output logic                      done_valid_o,
  output logic [`VLDU_ID_W-1:0]     done_id_o
);
  import vldu_pkg::*;

  localparam int unsigned DEPTH = `VLDU_INSN_DEPTH;
  localparam int unsigned PNT_W = $clog2(DEPTH);

  load_insn_t queue_q [DEPTH];

  // Accepted, issuing and committing heads; depth is a power of two so pointers wrap
  logic [PNT_W-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Entries still to issue, entries still to commit
  logic [PNT_W:0]   issue_cnt_q, commit_cnt_q;
  logic             accept;

  assign req_ready_o   = (commit_cnt_q != DEPTH[PNT_W:0]);
  assign accept        = req_valid_i && req_ready_o;
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_insn_o  = queue_q[issue_pnt_q];

  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_q[accept_pnt_q] <= req_insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_valid_o <= 1'b0;
      done_id_o    <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (commit_i) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + accept - issue_done_i;
      commit_cnt_q <= commit_cnt_q + accept - commit_i;
      // Report the retired head one cycle after its last word leaves
      done_valid_o <= commit_i;
      if (commit_i) begin
        done_id_o <= queue_q[commit_pnt_q].id;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/vldu_wb_fetch.sv
// Wishbone classic read fetch stage

`timescale 1ns/1ps
`default_nettype none

`include "vldu_settings.svh"

module vldu_wb_fetch (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  vldu_pkg::load_insn_t         issue_insn_i,
  input  wire logic                    issue_valid_i,
  output logic                         issue_done_o,
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output logic [`VLDU_ADDR_W-1:0]      wb_adr_o,
  input  wire logic [`VLDU_LANE_W-1:0] wb_dat_i,
  input  wire logic                    wb_ack_i,
  vldu_beat_if.src                     beat
);
  import vldu_pkg::*;

  fetch_state_e            state_q;
  // Word index within the issuing instruction
  logic [`VLDU_VL_W-4:0]   idx_q;
  logic [`VLDU_LANE_W-1:0] data_q;
  logic [`VLDU_VL_W-1:0]   vl_bytes;
  logic                    xfer;

  assign vl_bytes = issue_insn_i.vl << issue_insn_i.sew;
  assign xfer     = beat.valid && beat.ready;

  // Head stays put until issue_done, so the address is stable through REQ
  assign wb_cyc_o = (state_q == REQ);
  assign wb_stb_o = (state_q == REQ);
  assign wb_adr_o = issue_insn_i.base + `VLDU_ADDR_W'({idx_q, 3'b000});

  assign beat.valid    = (state_q == HOLD);
  assign beat.data     = data_q;
  assign beat.sew      = issue_insn_i.sew;
  assign beat.vd       = issue_insn_i.vd;
  assign beat.vl_bytes = vl_bytes;
  assign beat.first    = (idx_q == '0);
  // Last word index is the byte count rounded up to 8, minus one
  assign beat.last     = (idx_q == (vl_bytes - 1'b1) >> 3);

  assign issue_done_o = xfer && beat.last;

  // Beat register captures the read data in the ack cycle
  always_ff @(posedge clk_i) begin
    if (state_q == REQ && wb_ack_i) begin
      data_q <= wb_dat_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        IDLE: if (issue_valid_i) state_q <= REQ;
        REQ:  if (wb_ack_i) state_q <= HOLD;
        HOLD: begin
          // Next read starts only once the packer took the beat
          if (xfer) begin
            state_q <= beat.last ? IDLE : REQ;
            idx_q   <= beat.last ? '0 : idx_q + 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/vldu_word_packer.sv
// Beat to register-file word packer

`timescale 1ns/1ps
`default_nettype none

`include "vldu_settings.svh"

module vldu_word_packer (
  input  wire logic                                      clk_i,
  input  wire logic                                      rst_ni,
  vldu_beat_if.snk                                       beat,
  output logic                                           push_o,
  output logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W-1:0]    push_wdata_o,
  output logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W/8-1:0]  push_be_o,
  output vldu_pkg::vrf_addr_t                            push_addr_o,
  output logic                                           push_last_o,
  input  wire logic                                      full_i
);
  import vldu_pkg::*;

  localparam int unsigned BEAT_BYTES = `VLDU_LANE_W / 8;
  localparam int unsigned WORD_BYTES = `VLDU_NR_LANES * BEAT_BYTES;
  localparam int unsigned BEAT_W     = $clog2(`VLDU_NR_LANES);
  localparam int unsigned WORD_W     = $clog2(`VLDU_REG_WORDS);

  logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W-1:0]   wdata_q, wdata_d;
  logic [`VLDU_NR_LANES-1:0][BEAT_BYTES-1:0]     be_q, be_d;
  logic [BEAT_W-1:0] beat_idx_q, cur_beat;
  logic [WORD_W-1:0] word_cnt_q, cur_word;
  logic              xfer;

  // Stall the fetch stage while both result entries are taken
  assign beat.ready = !full_i;
  assign xfer       = beat.valid && beat.ready;

  // A new instruction restarts both counters
  assign cur_beat = beat.first ? '0 : beat_idx_q;
  assign cur_word = beat.first ? '0 : word_cnt_q;

  //////////////////////////////////////////////////////////////////////
  // Element shuffle
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_merge
    int unsigned seq;
    int unsigned elem;
    int unsigned lane;
    int unsigned offs;
    wdata_d = wdata_q;
    // Enables start clean with each word
    be_d    = (cur_beat == '0) ? '0 : be_q;
    for (int k = 0; k < BEAT_BYTES; k++) begin
      // Sequential byte in the word, its element and byte in element
      seq  = cur_beat * BEAT_BYTES + k;
      elem = seq >> beat.sew;
      lane = elem % `VLDU_NR_LANES;
      offs = ((elem / `VLDU_NR_LANES) << beat.sew) + (seq - (elem << beat.sew));
      wdata_d[lane][8*offs +: 8] = beat.data[8*k +: 8];
      // Tail bytes past vl stay disabled
      be_d[lane][offs] = (cur_word * WORD_BYTES + seq) < beat.vl_bytes;
    end
  end

  // Word leaves with its final beat, or early with the instruction's last
  assign push_o       = xfer && (cur_beat == BEAT_W'(`VLDU_NR_LANES - 1) || beat.last);
  assign push_wdata_o = wdata_d;
  assign push_be_o    = be_d;
  assign push_addr_o  = vrf_addr_t'(beat.vd * `VLDU_REG_WORDS + cur_word);
  assign push_last_o  = beat.last;

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      wdata_q <= wdata_d;
      be_q    <= be_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_idx_q <= '0;
      word_cnt_q <= '0;
    end else if (xfer) begin
      beat_idx_q <= push_o ? '0 : cur_beat + 1'b1;
      word_cnt_q <= push_o ? cur_word + 1'b1 : cur_word;
    end
  end

endmodule

`default_nettype wire

// File: logic/vldu_result_queue.sv
// Two-entry result queue with lane write-back

`timescale 1ns/1ps
`default_nettype none

`include "vldu_settings.svh"

module vldu_result_queue (
  input  wire logic                                            clk_i,
  input  wire logic                                            rst_ni,
  input  wire logic                                            push_i,
  input  wire logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W-1:0]     push_wdata_i,
  input  wire logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W/8-1:0]   push_be_i,
  input  vldu_pkg::vrf_addr_t                                  push_addr_i,
  input  wire logic                                            push_last_i,
  output logic                                                 full_o,
  output logic [`VLDU_NR_LANES-1:0]                            lane_req_o,
  input  wire logic [`VLDU_NR_LANES-1:0]                       lane_gnt_i,
  output vldu_pkg::vrf_addr_t [`VLDU_NR_LANES-1:0]             lane_addr_o,
  output logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W-1:0]          lane_wdata_o,
  output logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W/8-1:0]        lane_be_o,
  output logic                                                 commit_o
);
  import vldu_pkg::*;

  localparam int unsigned DEPTH = 2;
  localparam int unsigned PNT_W = $clog2(DEPTH);

  // Entry payload
  logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W-1:0]   wdata_q [DEPTH];
  logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W/8-1:0] be_q [DEPTH];
  vrf_addr_t                                     addr_q [DEPTH];
  logic                                          last_q [DEPTH];

  // Lanes still to write, per entry
  logic [`VLDU_NR_LANES-1:0] valid_q [DEPTH];
  logic [PNT_W-1:0]          wr_pnt_q, rd_pnt_q;
  logic [PNT_W:0]            cnt_q;
  logic                      pop;

  assign full_o = (cnt_q == DEPTH[PNT_W:0]);

  // Head entry drives every lane
  assign lane_req_o   = valid_q[rd_pnt_q];
  assign lane_addr_o  = {`VLDU_NR_LANES{addr_q[rd_pnt_q]}};
  assign lane_wdata_o = wdata_q[rd_pnt_q];
  assign lane_be_o    = be_q[rd_pnt_q];

  // Pop the cycle after the last lane grant cleared the head
  assign pop      = (cnt_q != '0) && (valid_q[rd_pnt_q] == '0);
  assign commit_o = pop && last_q[rd_pnt_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      wdata_q[wr_pnt_q] <= push_wdata_i;
      be_q[wr_pnt_q]    <= push_be_i;
      addr_q[wr_pnt_q]  <= push_addr_i;
      last_q[wr_pnt_q]  <= push_last_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        valid_q[i] <= '0;
      end
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      for (int l = 0; l < `VLDU_NR_LANES; l++) begin
        if (lane_req_o[l] && lane_gnt_i[l]) begin
          valid_q[rd_pnt_q][l] <= 1'b0;
        end
      end
      // Push only targets a free entry, never the granted head
      if (push_i) begin
        valid_q[wr_pnt_q] <= '1;
        wr_pnt_q          <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + push_i - pop;
    end
  end

endmodule

`default_nettype wire

// File: logic/vldu_top.sv
// Vector load unit top level

`timescale 1ns/1ps
`default_nettype none

`include "vldu_settings.svh"

module vldu_top (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_ni,
  // Load requests
  input  wire logic                                          req_valid_i,
  input  wire logic [`VLDU_ID_W-1:0]                         req_id_i,
  input  wire logic [4:0]                                    req_vd_i,
  input  vldu_pkg::sew_e                                     req_sew_i,
  input  wire logic [`VLDU_VL_W-1:0]                         req_vl_i,
  input  wire logic [`VLDU_ADDR_W-1:0]                       req_base_i,
  output logic                                               req_ready_o,
  // Wishbone classic read master
  output logic                                               wb_cyc_o,
  output logic                                               wb_stb_o,
  output logic [`VLDU_ADDR_W-1:0]                            wb_adr_o,
  input  wire logic [`VLDU_LANE_W-1:0]                       wb_dat_i,
  input  wire logic                                          wb_ack_i,
  // Lane write-back
  output logic [`VLDU_NR_LANES-1:0]                          lane_req_o,
  input  wire logic [`VLDU_NR_LANES-1:0]                     lane_gnt_i,
  output vldu_pkg::vrf_addr_t [`VLDU_NR_LANES-1:0]           lane_addr_o,
  output logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W-1:0]        lane_wdata_o,
  output logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W/8-1:0]      lane_be_o,
  // Completion
  output logic                                               done_valid_o,
  output logic [`VLDU_ID_W-1:0]                              done_id_o
);
  import vldu_pkg::*;

  load_insn_t req_insn, issue_insn;
  logic       issue_valid, issue_done, commit;
  logic       push, push_last, full;
  vrf_addr_t  push_addr;
  logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W-1:0]   push_wdata;
  logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W/8-1:0] push_be;

  assign req_insn = '{id: req_id_i, vd: req_vd_i, sew: req_sew_i,
                      vl: req_vl_i, base: req_base_i};

  vldu_beat_if beat ();

  vldu_insn_queue u_insn_queue (
    .clk_i, .rst_ni,
    .req_valid_i, .req_insn_i(req_insn), .req_ready_o,
    .issue_insn_o(issue_insn), .issue_valid_o(issue_valid), .issue_done_i(issue_done),
    .commit_i(commit), .done_valid_o, .done_id_o
  );

  vldu_wb_fetch u_fetch (
    .clk_i, .rst_ni,
    .issue_insn_i(issue_insn), .issue_valid_i(issue_valid), .issue_done_o(issue_done),
    .wb_cyc_o, .wb_stb_o, .wb_adr_o, .wb_dat_i, .wb_ack_i,
    .beat(beat.src)
  );

  vldu_word_packer u_packer (
    .clk_i, .rst_ni,
    .beat(beat.snk),
    .push_o(push), .push_wdata_o(push_wdata), .push_be_o(push_be),
    .push_addr_o(push_addr), .push_last_o(push_last), .full_i(full)
  );

  vldu_result_queue u_result_queue (
    .clk_i, .rst_ni,
    .push_i(push), .push_wdata_i(push_wdata), .push_be_i(push_be),
    .push_addr_i(push_addr), .push_last_i(push_last), .full_o(full),
    .lane_req_o, .lane_gnt_i, .lane_addr_o, .lane_wdata_o, .lane_be_o,
    .commit_o(commit)
  );

endmodule

`default_nettype wire

// File: tb/vldu_assertions.sv
// Vector load unit handshake assertions

`timescale 1ns/1ps
`default_nettype none

`include "vldu_settings.svh"

module vldu_assertions (
  input wire logic                                        clk_i,
  input wire logic                                        rst_ni,
  input wire logic                                        wb_cyc_o,
  input wire logic                                        wb_stb_o,
  input wire logic [`VLDU_ADDR_W-1:0]                     wb_adr_o,
  input wire logic                                        wb_ack_i,
  input wire logic [`VLDU_NR_LANES-1:0]                   lane_req_o,
  input wire logic [`VLDU_NR_LANES-1:0]                   lane_gnt_i,
  input vldu_pkg::vrf_addr_t [`VLDU_NR_LANES-1:0]         lane_addr_o,
  input wire logic [`VLDU_NR_LANES-1:0][`VLDU_LANE_W-1:0] lane_wdata_o,
  input wire logic                                        done_valid_o
);

  // Cycle and strobe hold with a stable address until ack
  a_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_cyc_o && wb_stb_o && !wb_ack_i) |=> (wb_cyc_o && wb_stb_o && $stable(wb_adr_o)))
    else $error("Wishbone cycle dropped or address moved before ack");

  // Completion is a single-cycle pulse
  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_valid_o |=> !done_valid_o)
    else $error("Completion pulse lasted longer than one cycle");

  for (genvar l = 0; l < `VLDU_NR_LANES; l++) begin : g_lane
    // Waiting lane request keeps its payload
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (lane_req_o[l] && !lane_gnt_i[l]) |=>
        (lane_req_o[l] && $stable(lane_wdata_o[l]) && $stable(lane_addr_o[l])))
      else $error("Lane request dropped or changed before grant");
  end

endmodule

`default_nettype wire

// File: tb/vldu_checker.sv
// Vector load unit result checker

`timescale 1ns/1ps
`default_nettype none

module vldu_checker (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             req_valid_i,
  input  wire logic             req_ready_o,
  input  wire logic [2:0]       req_id_i,
  input  wire logic [4:0]       req_vd_i,
  input  wire logic [1:0]       req_sew_i,
  input  wire logic [8:0]       req_vl_i,
  input  wire logic [31:0]      req_base_i,
  input  wire logic             wb_cyc_o,
  input  wire logic             wb_stb_o,
  input  wire logic [31:0]      wb_adr_o,
  input  wire logic             wb_ack_i,
  input  wire logic [3:0]       lane_req_o,
  input  wire logic [3:0]       lane_gnt_i,
  input  wire logic [3:0][7:0]  lane_addr_o,
  input  wire logic [3:0][63:0] lane_wdata_o,
  input  wire logic [3:0][7:0]  lane_be_o,
  input  wire logic             done_valid_o,
  input  wire logic [2:0]       done_id_o,
  output int                    errors_o,
  output logic                  idle_o
);

  // Expected lane writes as {addr, be, data}
  logic [79:0] exp_q [4][$];
  logic [31:0] adr_q [$];
  logic [2:0]  id_q [$];
  logic [3:0]  prev_req, prev_gnt;
  logic [79:0] prev_word [4];

  // Memory pattern of the Wishbone model
  function automatic logic [7:0] mem_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'ha5;
  endfunction

  // One lane's word w of a load by the element shuffle rule
  function automatic logic [79:0] ref_lane(input int sew, input int vl, input int vd,
                                           input logic [31:0] base, input int w,
                                           input int l);
    int size;
    int e;
    int offs;
    int g;
    logic [63:0] d;
    logic [7:0]  be;
    logic [7:0]  addr;
    size = 1 << sew;
    d    = '0;
    be   = '0;
    for (int s = 0; s < 32; s++) begin
      e = s / size;
      if (e % 4 == l) begin
        offs = (e / 4) * size + s % size;
        g    = w * 32 + s;
        d[8*offs +: 8] = mem_byte(base + 32'(g));
        be[offs]       = (g < vl * size);
      end
    end
    addr = 8'(vd * 8 + w);
    return {addr, be, d};
  endfunction

  assign idle_o = (adr_q.size() == 0) && (id_q.size() == 0) &&
                  (exp_q[0].size() == 0) && (exp_q[1].size() == 0) &&
                  (exp_q[2].size() == 0) && (exp_q[3].size() == 0);

  initial begin
    errors_o = 0;
    prev_req = '0;
    prev_gnt = '0;
  end

  // Sample between edges where every signal is settled
  always @(negedge clk_i) begin
    int bytes;
    logic [79:0] exp;
    logic [79:0] got;
    logic [63:0] mask;
    if (rst_ni) begin
      //////////////////////////////////////////////////////////////////////
      // Accepted loads
      //////////////////////////////////////////////////////////////////////
      if (req_valid_i && req_ready_o) begin
        bytes = int'(req_vl_i) << req_sew_i;
        id_q.push_back(req_id_i);
        for (int i = 0; i < (bytes + 7) / 8; i++) begin
          adr_q.push_back(req_base_i + 32'(8 * i));
        end
        for (int w = 0; w < (bytes + 31) / 32; w++) begin
          for (int l = 0; l < 4; l++) begin
            exp_q[l].push_back(ref_lane(int'(req_sew_i), int'(req_vl_i), int'(req_vd_i),
                                        req_base_i, w, l));
          end
        end
      end
      // Wishbone reads in address order
      if (wb_cyc_o && wb_stb_o && wb_ack_i) begin
        if (adr_q.size() == 0) begin
          $display("Unexpected Wishbone read at %0t", $time);
          errors_o++;
        end else if (wb_adr_o != adr_q[0]) begin
          $display("FAILED %0t: read address %h, expected %h", $time, wb_adr_o, adr_q[0]);
          errors_o++;
          void'(adr_q.pop_front());
        end else begin
          void'(adr_q.pop_front());
        end
      end
      // Lane writes compare enabled bytes only
      for (int l = 0; l < 4; l++) begin
        got = {lane_addr_o[l], lane_be_o[l], lane_wdata_o[l]};
        if (prev_req[l] && !prev_gnt[l] && (!lane_req_o[l] || got != prev_word[l])) begin
          $display("FAILED %0t: lane %0d request changed before its grant", $time, l);
          errors_o++;
        end
        if (lane_req_o[l] && lane_gnt_i[l]) begin
          if (exp_q[l].size() == 0) begin
            $display("Lane %0d was written with no write outstanding at %0t", l, $time);
            errors_o++;
          end else begin
            exp = exp_q[l].pop_front();
            for (int k = 0; k < 8; k++) begin
              mask[8*k +: 8] = {8{exp[64+k]}};
            end
            if (got[79:64] != exp[79:64] || (got[63:0] & mask) != (exp[63:0] & mask)) begin
              $display("FAILED %0t: lane %0d wrote %h, expected %h", $time, l, got, exp);
              errors_o++;
            end
          end
        end
        prev_word[l] = got;
      end
      prev_req = lane_req_o;
      prev_gnt = lane_gnt_i;
      // Completions in acceptance order
      if (done_valid_o) begin
        if (id_q.size() == 0) begin
          $display("Completion with no load in flight at %0t", $time);
          errors_o++;
        end else begin
          if (done_id_o != id_q[0]) begin
            $display("FAILED %0t: done id %0d, expected %0d", $time, done_id_o, id_q[0]);
            errors_o++;
          end
          void'(id_q.pop_front());
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/vldu_tb.sv
// Vector load unit testbench

`timescale 1ns/1ps
`default_nettype none

module vldu_tb;
  import vldu_pkg::*;

  logic             clk_i;
  logic             rst_ni;
  logic             req_valid_i;
  logic [2:0]       req_id_i;
  logic [4:0]       req_vd_i;
  sew_e             req_sew_i;
  logic [8:0]       req_vl_i;
  logic [31:0]      req_base_i;
  logic             req_ready_o;
  logic             wb_cyc_o;
  logic             wb_stb_o;
  logic [31:0]      wb_adr_o;
  logic [63:0]      wb_dat_i;
  logic             wb_ack_i;
  logic [3:0]       lane_req_o;
  logic [3:0]       lane_gnt_i;
  vrf_addr_t [3:0]  lane_addr_o;
  logic [3:0][63:0] lane_wdata_o;
  logic [3:0][7:0]  lane_be_o;
  logic             done_valid_o;
  logic [2:0]       done_id_o;

  int          chk_errors;
  logic        chk_idle;
  int          tb_errors;
  logic [31:0] rng;
  int          wait_cnt;
  logic        gnt_en;
  logic [2:0]  next_id;

  vldu_top dut0 (.*);

  vldu_checker chk0 (
    .clk_i, .rst_ni, .req_valid_i, .req_ready_o, .req_id_i, .req_vd_i,
    .req_sew_i(req_sew_i), .req_vl_i, .req_base_i,
    .wb_cyc_o, .wb_stb_o, .wb_adr_o, .wb_ack_i,
    .lane_req_o, .lane_gnt_i, .lane_addr_o, .lane_wdata_o, .lane_be_o,
    .done_valid_o, .done_id_o, .errors_o(chk_errors), .idle_o(chk_idle)
  );

  bind vldu_top vldu_assertions u_assert (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Memory byte folded from every address byte
  function automatic logic [7:0] mem_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'ha5;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Wishbone memory and lane grants
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    logic [31:0] r;
    r   = xorshift(rng);
    rng <= r;
    lane_gnt_i <= gnt_en ? r[7:4] : 4'b0;
    wb_ack_i   <= 1'b0;
    if (wb_cyc_o && wb_stb_o && !wb_ack_i) begin
      if (wait_cnt == 0) begin
        wb_ack_i <= 1'b1;
        for (int k = 0; k < 8; k++) begin
          wb_dat_i[8*k +: 8] <= mem_byte(wb_adr_o + 32'(k));
        end
        // Random 0 to 3 cycle delay for the next read
        wait_cnt <= int'(r[1:0]);
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  task automatic send_load(input int sew, input int vl);
    int t;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_id_i    <= next_id;
    req_vd_i    <= rng[12:8];
    req_sew_i   <= sew_e'(sew);
    req_vl_i    <= 9'(vl);
    req_base_i  <= {16'h0001, rng[27:17], 5'b0} + {rng[29:28], 3'b000};
    next_id     <= next_id + 3'd1;
    t = 0;
    @(negedge clk_i);
    while (!req_ready_o && t < 2000) begin
      @(negedge clk_i);
      t++;
    end
    if (!req_ready_o) begin
      $display("Timeout: a load request was never accepted");
      tb_errors++;
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  initial begin
    int t;
    rng         = 32'h6f5e_13b7;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_id_i    = '0;
    req_vd_i    = '0;
    req_sew_i   = E8;
    req_vl_i    = '0;
    req_base_i  = '0;
    wb_dat_i    = '0;
    wb_ack_i    = 1'b0;
    lane_gnt_i  = '0;
    gnt_en      = 1'b0;
    wait_cnt    = 0;
    next_id     = '0;
    tb_errors   = 0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (!req_ready_o || wb_cyc_o || wb_stb_o || lane_req_o != '0 || done_valid_o) begin
      $display("FAILED %0t: outputs not idle after reset", $time);
      tb_errors++;
    end
    // Four small loads fill the queue while grants are withheld
    for (int i = 0; i < 4; i++) begin
      send_load(0, 8);
    end
    @(negedge clk_i);
    if (req_ready_o) begin
      $display("FAILED %0t: ready still high with a full queue", $time);
      tb_errors++;
    end
    repeat (20) @(posedge clk_i);
    gnt_en <= 1'b1;
    // Every element width with full, partial and short lengths
    for (int sew = 0; sew < 4; sew++) begin
      send_load(sew, 256 >> sew);
      send_load(sew, (256 >> sew) - 3);
      send_load(sew, 5);
      send_load(sew, 1);
    end
    t = 0;
    @(negedge clk_i);
    while (!chk_idle && t < 20000) begin
      @(negedge clk_i);
      t++;
    end
    if (!chk_idle) begin
      $display("Timeout: loads still outstanding at the end of the run");
      tb_errors++;
    end
    repeat (4) @(posedge clk_i);
    $display("Errors: %0d (checker %0d, testbench %0d)", chk_errors + tb_errors,
             chk_errors, tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/vldu_pkg.sv
logic/vldu_beat_if.sv
logic/vldu_insn_queue.sv
logic/vldu_wb_fetch.sv
logic/vldu_word_packer.sv
logic/vldu_result_queue.sv
logic/vldu_top.sv
tb/vldu_assertions.sv
tb/vldu_checker.sv
tb/vldu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the vector load unit simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module vldu_tb -Mdir obj_dir -o vldu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/vldu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation run returned an error"
  exit 1
fi

if echo "$out" | grep -q "^Simulation PASSED$"; then
  exit 0
fi
exit 1
